//--- msx_glue_pkg.sv
// MSX glue shared definitions
package msx_glue_pkg;

   // ========================================
   // Widths
   // ========================================
   localparam int STATUS_W    = 64;
   localparam int DIM_W       = 12;
   localparam int DDR3_ADDR_W = 28;
   localparam int INDEX_W     = 16;
   localparam int IMG_SIZE_W  = 64;

   // ========================================
   // Host status word bit positions
   // ========================================
   localparam int ST_RESET       = 0;
   localparam int ST_AR_LO       = 1;
   localparam int ST_FX_LO       = 3;
   localparam int ST_SCALE_LO    = 6;
   localparam int ST_TAPE_REWIND = 9;
   localparam int ST_DETACH      = 10;
   localparam int ST_VCROP       = 40;

   // Download index of a cassette image, low six bits only
   localparam logic [5:0] CAS_INDEX = 6'd5;

   // Custom aspect ratio values for the HDMI scaler
   localparam logic [DIM_W-1:0] AR_X_NORMAL = 12'd400;
   localparam logic [DIM_W-1:0] AR_X_WIDE   = 12'd340;
   localparam logic [DIM_W-1:0] AR_Y        = 12'd300;

   // Aspect ratio menu field
   typedef enum logic [1:0] {
      AR_ORIGINAL = 2'd0,
      AR_FULL     = 2'd1,
      AR_CUSTOM1  = 2'd2,
      AR_CUSTOM2  = 2'd3
   } aspect_t;

   // Scandoubler effect menu field
   typedef enum logic [2:0] {
      FX_NONE     = 3'd0,
      FX_HQ2X_320 = 3'd1,
      FX_HQ2X_160 = 3'd2,
      FX_CRT25    = 3'd3,
      FX_CRT50    = 3'd4,
      FX_CRT75    = 3'd5
   } sd_fx_t;

endpackage

//--- osd_status_decode.sv
// Host status word decoder
`timescale 1ns/100ps

module osd_status_decode (
   input  logic [msx_glue_pkg::STATUS_W-1:0] status,
   input  logic                              reset_in,
   input  logic                              forced_scandoubler,
   output logic                              core_reset,
   output logic                              scandoubler,
   output logic                              hq2x,
   output logic [1:0]                        vga_sl,
   output logic [1:0]                        scale,
   output msx_glue_pkg::aspect_t             aspect,
   output logic                              vcrop_en
);
   import msx_glue_pkg::*;

   sd_fx_t fx;

   // Reset from the frame, the menu reset and the reset & detach entry
   assign core_reset = reset_in | status[ST_RESET] | status[ST_DETACH];

   assign fx       = sd_fx_t'(status[ST_FX_LO +: 3]);
   assign aspect   = aspect_t'(status[ST_AR_LO +: 2]);
   assign scale    = status[ST_SCALE_LO +: 2];
   assign vcrop_en = status[ST_VCROP];

   // Any effect needs the doubled line rate
   assign scandoubler = (fx != FX_NONE) || forced_scandoubler;

   always_comb begin
      hq2x   = 1'b0;
      vga_sl = 2'd0;
      case (fx)
         FX_HQ2X_320,
         FX_HQ2X_160: hq2x = 1'b1;
         // CRT levels 25/50/75 map to scanline codes 1..3
         FX_CRT25,
         FX_CRT50,
         FX_CRT75:    vga_sl = 2'(fx - 3'd2);
         default: begin
            hq2x   = 1'b0;
            vga_sl = 2'd0;
         end
      endcase
   end

endmodule

//--- video_crop.sv
// HDMI vertical crop and aspect
`timescale 1ns/100ps

module video_crop (
   input  logic                           clk21m,
   input  logic                           arst_n,
   input  logic [msx_glue_pkg::DIM_W-1:0] hdmi_width,
   input  logic [msx_glue_pkg::DIM_W-1:0] hdmi_height,
   input  logic                           scandoubler,
   input  logic                           vcrop_en,
   input  msx_glue_pkg::aspect_t          aspect,
   output logic [msx_glue_pkg::DIM_W-1:0] crop_size,
   output logic [msx_glue_pkg::DIM_W-1:0] arx,
   output logic [msx_glue_pkg::DIM_W-1:0] ary
);
   import msx_glue_pkg::*;

   logic             wide_fmt;
   logic             tall_fmt;
   logic [DIM_W-1:0] crop_d;
   logic             wide_d;
   logic [DIM_W-1:0] crop_q;
   logic             wide_q;

   // Width against 1.5x height, one extra bit so the sum cannot wrap
   assign wide_fmt = ({1'b0, hdmi_width} >=
                      ({1'b0, hdmi_height} + {2'b00, hdmi_height[DIM_W-1:1]}));
   // 4:3 modes such as 1920x1440 fail the check above
   assign tall_fmt = (hdmi_width >= 12'd1440);

   // ========================================
   // Crop lookup
   // ========================================
   always_comb begin
      crop_d = '0;
      wide_d = 1'b0;
      if (!scandoubler && wide_fmt) begin
         case (hdmi_height)
            12'd480:  crop_d = 12'd240;
            12'd600: begin
               crop_d = 12'd200;
               wide_d = vcrop_en;
            end
            12'd720:  crop_d = 12'd240;
            12'd768:  crop_d = 12'd256;
            12'd800: begin
               crop_d = 12'd200;
               wide_d = vcrop_en;
            end
            12'd1080: crop_d = 12'd216;
            12'd1200: crop_d = 12'd240;
            default:  crop_d = '0;
         endcase
      end else if (!scandoubler && tall_fmt) begin
         case (hdmi_height)
            12'd1440: crop_d = 12'd240;
            12'd1536: crop_d = 12'd256;
            default:  crop_d = '0;
         endcase
      end
   end

   always_ff @(posedge clk21m or negedge arst_n) begin
      if (!arst_n) begin
         crop_q <= '0;
         wide_q <= 1'b0;
      end else begin
         crop_q <= crop_d;
         wide_q <= wide_d;
      end
   end

   assign crop_size = vcrop_en ? crop_q : '0;

   // ========================================
   // Aspect ratio
   // ========================================
   always_comb begin
      case (aspect)
         AR_CUSTOM1,
         AR_CUSTOM2: begin
            arx = wide_q ? AR_X_WIDE : AR_X_NORMAL;
            ary = AR_Y;
         end
         default: begin
            // Original wraps to all ones, full screen gives zero
            arx = {{(DIM_W-2){1'b0}}, aspect} - DIM_W'(1);
            ary = '0;
         end
      endcase
   end

endmodule

//--- sd_route.sv
// SD card SPI steering and activity LEDs
`timescale 1ns/100ps

module sd_route #(
   parameter int ACT_HOLD = 1000000
) (
   input  logic                                clk21m,
   input  logic                                arst_n,
   input  logic                                img_mounted,
   input  logic [msx_glue_pkg::IMG_SIZE_W-1:0] img_size,
   input  logic                                sd_clk_core,
   input  logic                                sd_mosi_core,
   input  logic                                sd_miso_pin,
   input  logic                                vsd_miso,
   output logic                                sd_cs,
   output logic                                sd_sck,
   output logic                                sd_mosi,
   output logic                                sd_miso_core,
   output logic                                led_user,
   output logic [1:0]                          led_disk
);
   import msx_glue_pkg::*;

   localparam int CNT_W = $clog2(ACT_HOLD + 1);

   logic             vsd_sel;
   logic             old_mosi;
   logic             old_miso;
   logic             sd_act;
   logic [CNT_W-1:0] timeout;
   logic             toggled;

   // ========================================
   // Card select
   // ========================================
   // A mounted image of non-zero size selects the virtual card
   always_ff @(posedge clk21m or negedge arst_n) begin
      if (!arst_n) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted) begin
         vsd_sel <= |img_size;
      end
   end

   // Physical slot deselected and quiet while the virtual card is used
   assign sd_cs        = vsd_sel;
   assign sd_sck       = sd_clk_core & ~vsd_sel;
   assign sd_mosi      = sd_mosi_core & ~vsd_sel;
   assign sd_miso_core = vsd_sel ? vsd_miso : sd_miso_pin;

   // ========================================
   // Activity timer
   // ========================================
   assign toggled = (old_mosi ^ sd_mosi_core) | (old_miso ^ sd_miso_core);

   // Counter starts expired so the LED is dark out of reset
   always_ff @(posedge clk21m or negedge arst_n) begin
      if (!arst_n) begin
         old_mosi <= 1'b0;
         old_miso <= 1'b0;
         timeout  <= CNT_W'(ACT_HOLD);
         sd_act   <= 1'b0;
      end else begin
         old_mosi <= sd_mosi_core;
         old_miso <= sd_miso_core;
         sd_act   <= (timeout < CNT_W'(ACT_HOLD));
         if (toggled) begin
            timeout <= '0;
         end else if (timeout < CNT_W'(ACT_HOLD)) begin
            timeout <= timeout + 1'b1;
         end
      end
   end

   // User LED for the virtual card, disk LED for the slot
   assign led_user = vsd_sel & sd_act;
   assign led_disk = {1'b1, ~vsd_sel & sd_act};

endmodule

//--- tape_ctrl.sv
// Cassette playback control
`timescale 1ns/100ps

module tape_ctrl (
   input  logic                                 clk21m,
   input  logic                                 arst_n,
   input  logic                                 ioctl_download,
   input  logic [msx_glue_pkg::INDEX_W-1:0]     ioctl_index,
   input  logic                                 motor,
   input  logic                                 tape_rewind_req,
   input  logic                                 core_reset,
   input  logic                                 dl_request,
   input  logic [msx_glue_pkg::DDR3_ADDR_W-1:0] dl_addr,
   input  logic                                 dl_rd,
   input  logic [msx_glue_pkg::DDR3_ADDR_W-1:0] cas_addr,
   input  logic                                 cas_rd,
   output logic                                 play,
   output logic                                 rewind,
   output logic [msx_glue_pkg::DDR3_ADDR_W-1:0] ddr3_addr,
   output logic                                 ddr3_rd
);
   import msx_glue_pkg::*;

   logic is_cas;
   logic is_cas_last;
   logic cas_load;

   // Download currently writing a CAS image
   assign is_cas = ioctl_download & (ioctl_index[5:0] == CAS_INDEX);

   // ========================================
   // Load latch
   // ========================================
   // Falling edge of the CAS download marks a loaded tape
   always_ff @(posedge clk21m or negedge arst_n) begin
      if (!arst_n) begin
         is_cas_last <= 1'b0;
         cas_load    <= 1'b0;
      end else begin
         is_cas_last <= is_cas;
         if (is_cas_last && !is_cas) begin
            cas_load <= 1'b1;
         end
      end
   end

   // Motor relay is active low on the MSX side
   assign play = cas_load & ~motor;

   // Back to the start on a menu request, a new image or a core reset
   assign rewind = tape_rewind_req | is_cas | core_reset;

   // ========================================
   // DDR3 read port sharing
   // ========================================
   // ROM download engine has priority over the cassette reader
   assign ddr3_addr = dl_request ? dl_addr : cas_addr;
   assign ddr3_rd   = dl_request ? dl_rd   : cas_rd;

endmodule

//--- msx_glue_top.sv
// MSX core glue top level
`timescale 1ns/100ps

module msx_glue_top #(
   parameter int ACT_HOLD = 1000000
) (
   input  logic                                 clk21m,
   input  logic                                 arst_n,
   // Host menu
   input  logic [msx_glue_pkg::STATUS_W-1:0]    status,
   input  logic                                 reset_in,
   input  logic                                 forced_scandoubler,
   output logic                                 core_reset,
   output logic                                 scandoubler,
   output logic                                 hq2x,
   output logic [1:0]                           vga_sl,
   output logic [1:0]                           scale,
   // HDMI scaler
   input  logic [msx_glue_pkg::DIM_W-1:0]       hdmi_width,
   input  logic [msx_glue_pkg::DIM_W-1:0]       hdmi_height,
   output logic [msx_glue_pkg::DIM_W-1:0]       crop_size,
   output logic [msx_glue_pkg::DIM_W-1:0]       arx,
   output logic [msx_glue_pkg::DIM_W-1:0]       ary,
   // SD card
   input  logic                                 img_mounted,
   input  logic [msx_glue_pkg::IMG_SIZE_W-1:0]  img_size,
   input  logic                                 sd_clk_core,
   input  logic                                 sd_mosi_core,
   input  logic                                 sd_miso_pin,
   input  logic                                 vsd_miso,
   output logic                                 sd_cs,
   output logic                                 sd_sck,
   output logic                                 sd_mosi,
   output logic                                 sd_miso_core,
   output logic                                 led_user,
   output logic [1:0]                           led_disk,
   // Tape and DDR3
   input  logic                                 ioctl_download,
   input  logic [msx_glue_pkg::INDEX_W-1:0]     ioctl_index,
   input  logic                                 motor,
   input  logic                                 dl_request,
   input  logic [msx_glue_pkg::DDR3_ADDR_W-1:0] dl_addr,
   input  logic                                 dl_rd,
   input  logic [msx_glue_pkg::DDR3_ADDR_W-1:0] cas_addr,
   input  logic                                 cas_rd,
   output logic                                 play,
   output logic                                 rewind,
   output logic [msx_glue_pkg::DDR3_ADDR_W-1:0] ddr3_addr,
   output logic                                 ddr3_rd
);
   import msx_glue_pkg::*;

   aspect_t aspect;
   logic    vcrop_en;

   osd_status_decode i_osd_status_decode (
      .status             (status),
      .reset_in           (reset_in),
      .forced_scandoubler (forced_scandoubler),
      .core_reset         (core_reset),
      .scandoubler        (scandoubler),
      .hq2x               (hq2x),
      .vga_sl             (vga_sl),
      .scale              (scale),
      .aspect             (aspect),
      .vcrop_en           (vcrop_en)
   );

   video_crop i_video_crop (
      .clk21m      (clk21m),
      .arst_n      (arst_n),
      .hdmi_width  (hdmi_width),
      .hdmi_height (hdmi_height),
      .scandoubler (scandoubler),
      .vcrop_en    (vcrop_en),
      .aspect      (aspect),
      .crop_size   (crop_size),
      .arx         (arx),
      .ary         (ary)
   );

   sd_route #(
      .ACT_HOLD (ACT_HOLD)
   ) i_sd_route (
      .clk21m       (clk21m),
      .arst_n       (arst_n),
      .img_mounted  (img_mounted),
      .img_size     (img_size),
      .sd_clk_core  (sd_clk_core),
      .sd_mosi_core (sd_mosi_core),
      .sd_miso_pin  (sd_miso_pin),
      .vsd_miso     (vsd_miso),
      .sd_cs        (sd_cs),
      .sd_sck       (sd_sck),
      .sd_mosi      (sd_mosi),
      .sd_miso_core (sd_miso_core),
      .led_user     (led_user),
      .led_disk     (led_disk)
   );

   tape_ctrl i_tape_ctrl (
      .clk21m          (clk21m),
      .arst_n          (arst_n),
      .ioctl_download  (ioctl_download),
      .ioctl_index     (ioctl_index),
      .motor           (motor),
      .tape_rewind_req (status[ST_TAPE_REWIND]),
      .core_reset      (core_reset),
      .dl_request      (dl_request),
      .dl_addr         (dl_addr),
      .dl_rd           (dl_rd),
      .cas_addr        (cas_addr),
      .cas_rd          (cas_rd),
      .play            (play),
      .rewind          (rewind),
      .ddr3_addr       (ddr3_addr),
      .ddr3_rd         (ddr3_rd)
   );

endmodule

//--- tb_msx_glue.sv
// MSX glue testbench
`timescale 1ns/100ps

module tb_msx_glue;
   import msx_glue_pkg::*;

   localparam int ACT_HOLD = 16;
   localparam int MAX_ROWS = 64;

   typedef enum logic [1:0] {ROW_VIDEO, ROW_SD, ROW_TAPE} row_kind_t;

   typedef struct packed {
      logic [1:0]         kind;
      logic [2:0]         fx;
      logic               forced;
      logic [1:0]         ar;
      logic               vcrop;
      logic [DIM_W-1:0]   width;
      logic [DIM_W-1:0]   height;
      logic [DIM_W-1:0]   crop;
      logic [DIM_W-1:0]   arx;
      logic [DIM_W-1:0]   ary;
      logic [1:0]         sl;
      logic               hq;
      logic               sd;
      logic               mount_nz;
      logic [INDEX_W-1:0] idx;
      logic               motor;
      logic               dlreq;
      logic [2:0]         src;
      logic               rst;
      logic               rew;
      logic               play_dl;
      logic               play_end;
   } row_t;

   logic                   clk21m;
   logic                   arst_n;
   logic [STATUS_W-1:0]    status;
   logic                   reset_in;
   logic                   forced_scandoubler;
   logic                   core_reset;
   logic                   scandoubler;
   logic                   hq2x;
   logic [1:0]             vga_sl;
   logic [1:0]             scale;
   logic [DIM_W-1:0]       hdmi_width;
   logic [DIM_W-1:0]       hdmi_height;
   logic [DIM_W-1:0]       crop_size;
   logic [DIM_W-1:0]       arx;
   logic [DIM_W-1:0]       ary;
   logic                   img_mounted;
   logic [IMG_SIZE_W-1:0]  img_size;
   logic                   sd_clk_core;
   logic                   sd_mosi_core;
   logic                   sd_miso_pin;
   logic                   vsd_miso;
   logic                   sd_cs;
   logic                   sd_sck;
   logic                   sd_mosi;
   logic                   sd_miso_core;
   logic                   led_user;
   logic [1:0]             led_disk;
   logic                   ioctl_download;
   logic [INDEX_W-1:0]     ioctl_index;
   logic                   motor;
   logic                   dl_request;
   logic [DDR3_ADDR_W-1:0] dl_addr;
   logic                   dl_rd;
   logic [DDR3_ADDR_W-1:0] cas_addr;
   logic                   cas_rd;
   logic                   play;
   logic                   rewind;
   logic [DDR3_ADDR_W-1:0] ddr3_addr;
   logic                   ddr3_rd;

   row_t   rows [0:MAX_ROWS-1];
   int     n_rows;
   int     cur_row;
   int     errors;
   int     checks;
   int     cycles;
   int     limit;
   integer seed;

   msx_glue_top #(
      .ACT_HOLD (ACT_HOLD)
   ) i_msx_glue_top (
      .clk21m (clk21m), .arst_n (arst_n),
      .status (status), .reset_in (reset_in), .forced_scandoubler (forced_scandoubler),
      .core_reset (core_reset), .scandoubler (scandoubler), .hq2x (hq2x),
      .vga_sl (vga_sl), .scale (scale),
      .hdmi_width (hdmi_width), .hdmi_height (hdmi_height),
      .crop_size (crop_size), .arx (arx), .ary (ary),
      .img_mounted (img_mounted), .img_size (img_size),
      .sd_clk_core (sd_clk_core), .sd_mosi_core (sd_mosi_core),
      .sd_miso_pin (sd_miso_pin), .vsd_miso (vsd_miso),
      .sd_cs (sd_cs), .sd_sck (sd_sck), .sd_mosi (sd_mosi), .sd_miso_core (sd_miso_core),
      .led_user (led_user), .led_disk (led_disk),
      .ioctl_download (ioctl_download), .ioctl_index (ioctl_index), .motor (motor),
      .dl_request (dl_request), .dl_addr (dl_addr), .dl_rd (dl_rd),
      .cas_addr (cas_addr), .cas_rd (cas_rd),
      .play (play), .rewind (rewind), .ddr3_addr (ddr3_addr), .ddr3_rd (ddr3_rd)
   );

   initial begin
      clk21m = 1'b0;
      forever #5 clk21m = ~clk21m;
   end

   // ========================================
   // Compare tasks
   // ========================================
   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] row %0d %s = 0x%0h, expected 0x%0h", cur_row, name, got, exp);
      end
   endtask

   task automatic check_lvl(input string name, input logic [1:0] got, input logic [1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] row %0d %s = 0x%0h, expected 0x%0h", cur_row, name, got, exp);
      end
   endtask

   task automatic check_dim(input string name, input logic [DIM_W-1:0] got,
                            input logic [DIM_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] row %0d %s = 0x%0h, expected 0x%0h", cur_row, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input logic [DDR3_ADDR_W-1:0] got,
                             input logic [DDR3_ADDR_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] row %0d %s = 0x%0h, expected 0x%0h", cur_row, name, got, exp);
      end
   endtask

   // ========================================
   // Stimulus table
   // ========================================
   function automatic void add_video(input int fx, forced, ar, vcrop, w, h,
                                     input int crop, x, y, sl, hq, sd);
      row_t r;
      r = '0;
      r.kind = ROW_VIDEO;
      r.fx = fx[2:0];
      r.forced = forced[0];
      r.ar = ar[1:0];
      r.vcrop = vcrop[0];
      r.width = w[DIM_W-1:0];
      r.height = h[DIM_W-1:0];
      r.crop = crop[DIM_W-1:0];
      r.arx = x[DIM_W-1:0];
      r.ary = y[DIM_W-1:0];
      r.sl = sl[1:0];
      r.hq = hq[0];
      r.sd = sd[0];
      rows[n_rows] = r;
      n_rows++;
   endfunction

   function automatic void add_sd(input int nz);
      row_t r;
      r = '0;
      r.kind = ROW_SD;
      r.mount_nz = nz[0];
      rows[n_rows] = r;
      n_rows++;
   endfunction

   function automatic void add_tape(input int idx, mot, dlreq, src, rst, rew, pdl, pend);
      row_t r;
      r = '0;
      r.kind = ROW_TAPE;
      r.idx = idx[INDEX_W-1:0];
      r.motor = mot[0];
      r.dlreq = dlreq[0];
      r.src = src[2:0];
      r.rst = rst[0];
      r.rew = rew[0];
      r.play_dl = pdl[0];
      r.play_end = pend[0];
      rows[n_rows] = r;
      n_rows++;
   endfunction

   task automatic build_table();
      // fx forced ar vcrop width height crop arx ary vga_sl hq2x scandoubler
      add_video(0, 0, 0, 1, 1920, 1080, 216, 4095, 0, 0, 0, 0);
      add_video(0, 1, 0, 1, 1920, 1080, 0, 4095, 0, 0, 0, 1);
      add_video(1, 0, 0, 1, 1920, 1080, 0, 4095, 0, 0, 1, 1);
      add_video(1, 1, 0, 1, 1920, 1080, 0, 4095, 0, 0, 1, 1);
      add_video(2, 0, 0, 1, 1920, 1080, 0, 4095, 0, 0, 1, 1);
      add_video(2, 1, 0, 1, 1920, 1080, 0, 4095, 0, 0, 1, 1);
      add_video(3, 0, 0, 1, 1920, 1080, 0, 4095, 0, 1, 0, 1);
      add_video(3, 1, 0, 1, 1920, 1080, 0, 4095, 0, 1, 0, 1);
      add_video(4, 0, 0, 1, 1920, 1080, 0, 4095, 0, 2, 0, 1);
      add_video(4, 1, 0, 1, 1920, 1080, 0, 4095, 0, 2, 0, 1);
      add_video(5, 0, 0, 1, 1920, 1080, 0, 4095, 0, 3, 0, 1);
      add_video(5, 1, 0, 1, 1920, 1080, 0, 4095, 0, 3, 0, 1);
      // Crop table at width 1920
      add_video(0, 0, 0, 1, 1920, 480, 240, 4095, 0, 0, 0, 0);
      add_video(0, 0, 2, 1, 1920, 600, 200, 340, 300, 0, 0, 0);
      add_video(0, 0, 0, 1, 1920, 720, 240, 4095, 0, 0, 0, 0);
      add_video(0, 0, 0, 1, 1920, 768, 256, 4095, 0, 0, 0, 0);
      add_video(0, 0, 0, 1, 1920, 800, 200, 4095, 0, 0, 0, 0);
      add_video(0, 0, 0, 1, 1920, 1200, 240, 4095, 0, 0, 0, 0);
      add_video(0, 0, 0, 0, 1920, 480, 0, 4095, 0, 0, 0, 0);
      add_video(0, 0, 0, 0, 1920, 600, 0, 4095, 0, 0, 0, 0);
      add_video(0, 0, 0, 0, 1920, 720, 0, 4095, 0, 0, 0, 0);
      add_video(0, 0, 0, 0, 1920, 768, 0, 4095, 0, 0, 0, 0);
      add_video(0, 0, 0, 0, 1920, 800, 0, 4095, 0, 0, 0, 0);
      add_video(0, 0, 0, 0, 1920, 1200, 0, 4095, 0, 0, 0, 0);
      // 4:3 modes, an unlisted size, then the same with the scandoubler on
      add_video(0, 0, 0, 1, 1920, 1440, 240, 4095, 0, 0, 0, 0);
      add_video(0, 0, 0, 1, 2048, 1536, 256, 4095, 0, 0, 0, 0);
      add_video(0, 0, 0, 1, 1440, 1440, 240, 4095, 0, 0, 0, 0);
      add_video(0, 0, 0, 1, 1024, 768, 0, 4095, 0, 0, 0, 0);
      add_video(0, 1, 0, 1, 1920, 1440, 0, 4095, 0, 0, 0, 1);
      add_video(0, 1, 0, 1, 2048, 1536, 0, 4095, 0, 0, 0, 1);
      add_video(0, 1, 0, 1, 1440, 1440, 0, 4095, 0, 0, 0, 1);
      // Aspect codes
      add_video(0, 0, 0, 1, 1280, 800, 200, 4095, 0, 0, 0, 0);
      add_video(0, 0, 1, 1, 1280, 800, 200, 0, 0, 0, 0, 0);
      add_video(0, 0, 2, 1, 1280, 800, 200, 340, 300, 0, 0, 0);
      add_video(0, 0, 3, 1, 1280, 800, 200, 340, 300, 0, 0, 0);
      add_video(0, 0, 0, 0, 1280, 800, 0, 4095, 0, 0, 0, 0);
      add_video(0, 0, 1, 0, 1280, 800, 0, 0, 0, 0, 0, 0);
      add_video(0, 0, 2, 0, 1280, 800, 0, 400, 300, 0, 0, 0);
      add_video(0, 0, 3, 0, 1280, 800, 0, 400, 300, 0, 0, 0);
      add_video(0, 0, 1, 1, 1920, 1080, 216, 0, 0, 0, 0, 0);
      add_video(0, 0, 2, 1, 1920, 1080, 216, 400, 300, 0, 0, 0);
      add_video(0, 0, 3, 1, 1920, 1080, 216, 400, 300, 0, 0, 0);
      add_video(0, 0, 0, 0, 1920, 1080, 0, 4095, 0, 0, 0, 0);
      add_video(0, 0, 1, 0, 1920, 1080, 0, 0, 0, 0, 0, 0);
      add_video(0, 0, 2, 0, 1920, 1080, 0, 400, 300, 0, 0, 0);
      add_video(0, 0, 3, 0, 1920, 1080, 0, 400, 300, 0, 0, 0);
      // Image size non-zero, then zero
      add_sd(1);
      add_sd(0);
      // index motor dl_request source core_reset rewind play_during play_after
      // Source 1 reset bit, 2 detach bit, 3 reset_in, 4 tape rewind bit
      add_tape('h0003, 0, 1, 1, 1, 1, 0, 0);
      add_tape('h0041, 0, 0, 2, 1, 1, 0, 0);
      add_tape('h0007, 0, 1, 3, 1, 1, 0, 0);
      add_tape('h0002, 0, 0, 4, 0, 1, 0, 0);
      add_tape('h0000, 1, 1, 0, 0, 0, 0, 0);
      add_tape('h00C5, 1, 0, 0, 0, 1, 0, 0);
      add_tape('h0001, 0, 1, 0, 0, 0, 1, 1);
      add_tape('h0005, 0, 0, 0, 0, 1, 1, 1);
   endtask

   // ========================================
   // Row execution
   // ========================================
   // Random background with the decoded fields cleared, scale bits kept random
   task automatic make_status(input int fx, ar, vcrop, src,
                              output logic [STATUS_W-1:0] st, output logic [1:0] scl);
      st = {$random(seed), $random(seed)};
      scl = st[ST_SCALE_LO +: 2];
      st[ST_DETACH:0] = '0;
      st[ST_SCALE_LO +: 2] = scl;
      st[ST_VCROP] = vcrop[0];
      st[ST_FX_LO +: 3] = fx[2:0];
      st[ST_AR_LO +: 2] = ar[1:0];
      st[ST_RESET] = (src == 1);
      st[ST_DETACH] = (src == 2);
      st[ST_TAPE_REWIND] = (src == 4);
   endtask

   task automatic run_video(input row_t r);
      logic [STATUS_W-1:0] st;
      logic [1:0]          scl;
      make_status(r.fx, r.ar, r.vcrop, 0, st, scl);
      @(posedge clk21m);
      status <= st;
      forced_scandoubler <= r.forced;
      hdmi_width <= r.width;
      hdmi_height <= r.height;
      // Crop and aspect registers load on the next edge
      @(posedge clk21m);
      @(negedge clk21m);
      check_bit("core_reset", core_reset, 1'b0);
      check_bit("scandoubler", scandoubler, r.sd);
      check_bit("hq2x", hq2x, r.hq);
      check_lvl("vga_sl", vga_sl, r.sl);
      check_lvl("scale", scale, scl);
      check_dim("crop_size", crop_size, r.crop);
      check_dim("arx", arx, r.arx);
      check_dim("ary", ary, r.ary);
   endtask

   task automatic wait_quiet();
      repeat (ACT_HOLD + 4) @(posedge clk21m);
      @(negedge clk21m);
      check_bit("led_user", led_user, 1'b0);
      check_lvl("led_disk", led_disk, 2'b10);
   endtask

   task automatic run_sd(input row_t r);
      logic [IMG_SIZE_W-1:0] size;
      integer                rnd;
      logic                  lit;
      rnd = $random(seed);
      size = r.mount_nz ? ({$random(seed), $random(seed)} | 64'd1) : '0;
      @(posedge clk21m);
      img_mounted <= 1'b1;
      img_size <= size;
      @(posedge clk21m);
      img_mounted <= 1'b0;
      sd_clk_core <= rnd[2];
      sd_mosi_core <= rnd[1];
      sd_miso_pin <= rnd[0];
      vsd_miso <= ~rnd[0];
      @(negedge clk21m);
      check_bit("sd_cs", sd_cs, r.mount_nz);
      check_bit("sd_sck", sd_sck, r.mount_nz ? 1'b0 : rnd[2]);
      check_bit("sd_mosi", sd_mosi, r.mount_nz ? 1'b0 : rnd[1]);
      check_bit("sd_miso_core", sd_miso_core, r.mount_nz ? !rnd[0] : rnd[0]);
      wait_quiet();
      @(posedge clk21m);
      sd_mosi_core <= !rnd[1];
      lit = 1'b0;
      for (int i = 0; i < 3 && !lit; i++) begin
         @(posedge clk21m);
         @(negedge clk21m);
         lit = r.mount_nz ? led_user : led_disk[0];
      end
      checks++;
      if (!lit) begin
         errors++;
         $display("row %0d: activity LED stayed dark for 3 cycles after a toggle", cur_row);
      end
      if (r.mount_nz) begin
         check_bit("led_disk[0]", led_disk[0], 1'b0);
      end else begin
         check_bit("led_user", led_user, 1'b0);
      end
      check_bit("led_disk[1]", led_disk[1], 1'b1);
      check_bit("sd_mosi", sd_mosi, r.mount_nz ? 1'b0 : !rnd[1]);
      wait_quiet();
   endtask

   task automatic run_tape(input row_t r);
      logic [STATUS_W-1:0]    st;
      logic [1:0]             scl;
      logic [DDR3_ADDR_W-1:0] a_dl;
      logic [DDR3_ADDR_W-1:0] a_cas;
      integer                 rnd;
      make_status(0, 0, 0, r.src, st, scl);
      a_dl = $random(seed);
      a_cas = $random(seed);
      rnd = $random(seed);
      @(posedge clk21m);
      status <= st;
      reset_in <= (r.src == 3);
      ioctl_download <= 1'b1;
      ioctl_index <= r.idx;
      motor <= r.motor;
      dl_request <= r.dlreq;
      dl_addr <= a_dl;
      cas_addr <= a_cas;
      dl_rd <= rnd[0];
      cas_rd <= !rnd[0];
      @(negedge clk21m);
      check_bit("core_reset", core_reset, r.rst);
      check_bit("rewind", rewind, r.rew);
      check_bit("play", play, r.play_dl);
      check_addr("ddr3_addr", ddr3_addr, r.dlreq ? a_dl : a_cas);
      check_bit("ddr3_rd", ddr3_rd, r.dlreq ? rnd[0] : !rnd[0]);
      make_status(0, 0, 0, 0, st, scl);
      @(posedge clk21m);
      status <= st;
      reset_in <= 1'b0;
      ioctl_download <= 1'b0;
      // Load latch sets on the edge after the download ends
      @(posedge clk21m);
      @(negedge clk21m);
      check_bit("core_reset", core_reset, 1'b0);
      check_bit("rewind", rewind, 1'b0);
      check_bit("play", play, r.play_end);
   endtask

   // ========================================
   // Main sequence and watchdog
   // ========================================
   initial begin
      int    row_err;
      string label;
      seed = 27;
      errors = 0;
      checks = 0;
      n_rows = 0;
      cur_row = 0;
      limit = 0;
      arst_n = 1'b0;
      status = '0;
      reset_in = 1'b0;
      forced_scandoubler = 1'b0;
      hdmi_width = '0;
      hdmi_height = '0;
      img_mounted = 1'b0;
      img_size = '0;
      sd_clk_core = 1'b0;
      sd_mosi_core = 1'b0;
      sd_miso_pin = 1'b0;
      vsd_miso = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index = '0;
      motor = 1'b0;
      dl_request = 1'b0;
      dl_addr = '0;
      dl_rd = 1'b0;
      cas_addr = '0;
      cas_rd = 1'b0;
      build_table();
      limit = n_rows * (ACT_HOLD + 8) + 50;
      repeat (5) @(posedge clk21m);
      arst_n <= 1'b1;
      @(negedge clk21m);
      // LEDs dark and no tape loaded out of reset
      check_lvl("led_disk", led_disk, 2'b10);
      check_bit("play", play, 1'b0);
      for (int i = 0; i < n_rows; i++) begin
         cur_row = i;
         row_err = errors;
         case (rows[i].kind)
            ROW_VIDEO: begin
               label = "video";
               run_video(rows[i]);
            end
            ROW_SD: begin
               label = "sd";
               run_sd(rows[i]);
            end
            default: begin
               label = "tape";
               run_tape(rows[i]);
            end
         endcase
         if (errors == row_err) begin
            $display("row %0d %s: pass", i, label);
         end else begin
            $display("row %0d %s: %0d errors", i, label, errors - row_err);
         end
      end
      $display("Rows %0d, checks %0d, errors %0d", n_rows, checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      cycles = 0;
      while (limit == 0 || cycles < limit) begin
         @(posedge clk21m);
         cycles++;
      end
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
   end

endmodule

//--- compile.f
msx_glue_pkg.sv
osd_status_decode.sv
video_crop.sv
sd_route.sv
tape_ctrl.sv
msx_glue_top.sv
tb_msx_glue.sv

//--- Bender.yml
package:
  name: msx_glue

sources:
  - msx_glue_pkg.sv
  - osd_status_decode.sv
  - video_crop.sv
  - sd_route.sv
  - tape_ctrl.sv
  - msx_glue_top.sv
  - target: test
    files:
      - tb_msx_glue.sv
